//--- axo_pkg.sv
/*
 * Shared definitions of the axo RV32I core: widths, reset vector,
 * opcode, CSR and ALU encodings, and the trap cause.
 */
package axo_pkg;

    // Data and address width.
    localparam int xlen = 32;
    // Width of a register number.
    localparam int reg_addr_w = 5;
    // Reset program counter.
    localparam logic [xlen-1:0] entrypoint = 32'h4000_0000;
    // Hart id, read through mhartid.
    localparam logic [xlen-1:0] mhartid_value = 32'h0000_0000;
    // Illegal instruction cause.
    localparam logic [4:0] cause_illegal = 5'd2;

    // Major opcodes, bits 6:0 of the instruction.
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_op     = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_system = 7'b1110011
    } opcode_e;

    // Machine CSRs kept in this core.
    typedef enum logic [11:0] {
        csr_mstatus  = 12'h300,
        csr_mie      = 12'h304,
        csr_mtvec    = 12'h305,
        csr_mscratch = 12'h340,
        csr_mepc     = 12'h341,
        csr_mcause   = 12'h342,
        csr_mhartid  = 12'hf14
    } csr_addr_e;

    // ALU operations.
    // Encoded as {bit 30, funct3} of the instruction.
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

endpackage

//--- axo_fetch.sv
`timescale 1ns/1ps
/*
 * Fetch stage: program counter, redirect selection and the
 * fetch/decode pipeline register.
 */
module axo_fetch (
    input  logic                     clk,
    input  logic                     rst_latch,
    input  logic [axo_pkg::xlen-1:0] prog_data,
    input  logic                     trap,
    input  logic [axo_pkg::xlen-1:0] trap_vec,
    input  logic                     branch_error,
    input  logic                     predict_taken,
    input  logic [axo_pkg::xlen-1:0] branch_target,
    output logic [axo_pkg::xlen-1:0] prog_addr,
    output logic                     if_valid,
    output logic [axo_pkg::xlen-1:0] if_pc,
    output logic [axo_pkg::xlen-1:0] if_insn
);
    import axo_pkg::*;

    // Fetch address and the path not chosen by decode.
    logic [xlen-1:0] pc;
    logic [xlen-1:0] alt_pc;
    logic [xlen-1:0] next_pc;
    // Any change of flow from decode or execute.
    logic            redirect;

    assign prog_addr = pc;
    assign redirect  = trap || branch_error || predict_taken;

    // Next PC, highest priority first.
    always_comb begin
        if (trap) begin
            next_pc = trap_vec;
        end else if (branch_error) begin
            next_pc = alt_pc;
        end else if (predict_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            pc     <= entrypoint;
            alt_pc <= entrypoint;
        end else begin
            pc     <= next_pc;
            // PC here is already branch PC plus 4.
            alt_pc <= predict_taken ? pc : branch_target;
        end
    end

    // Fetch/decode register.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            if_valid <= 1'b0;
        end else begin
            // Word fetched this cycle is on the wrong path.
            if_valid <= !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if_pc   <= pc;
        if_insn <= prog_data;
    end

endmodule

//--- axo_regfile.sv
`timescale 1ns/1ps
/*
 * Integer register file, two read ports and one write port.
 */
module axo_regfile (
    input  logic                           clk,
    input  logic [axo_pkg::reg_addr_w-1:0] rs1,
    input  logic [axo_pkg::reg_addr_w-1:0] rs2,
    input  logic [axo_pkg::reg_addr_w-1:0] rd,
    input  logic                           we,
    input  logic [axo_pkg::xlen-1:0]       wdata,
    output logic [axo_pkg::xlen-1:0]       rs1_val,
    output logic [axo_pkg::xlen-1:0]       rs2_val
);

    // x1 to x31. x0 has no storage.
    logic [axo_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle writes reach decode through forwarding.
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- axo_decode.sv
`timescale 1ns/1ps
/*
 * Decode stage: instruction check, operands, forwarding, static
 * branch prediction and the decode/execute pipeline register.
 */
module axo_decode (
    input  logic                           clk,
    input  logic                           rst_latch,
    input  logic                           if_valid,
    input  logic [axo_pkg::xlen-1:0]       if_pc,
    input  logic [axo_pkg::xlen-1:0]       if_insn,
    input  logic [axo_pkg::xlen-1:0]       rs1_val,
    input  logic [axo_pkg::xlen-1:0]       rs2_val,
    input  logic [axo_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [axo_pkg::xlen-1:0]       ex_result,
    input  logic                           ex_valid,
    input  logic                           trap,
    input  logic                           branch_error,
    output logic [axo_pkg::reg_addr_w-1:0] rs1,
    output logic [axo_pkg::reg_addr_w-1:0] rs2,
    output logic                           predict_taken,
    output logic [axo_pkg::xlen-1:0]       branch_target,
    output logic                           id_valid,
    output logic [axo_pkg::xlen-1:0]       id_pc,
    output logic [axo_pkg::xlen-1:0]       id_insn,
    output logic [axo_pkg::xlen-1:0]       id_lhs,
    output logic [axo_pkg::xlen-1:0]       id_rhs,
    output logic [axo_pkg::reg_addr_w-1:0] id_rd,
    output axo_pkg::alu_op_e               id_alu_op,
    output logic                           id_predict,
    output logic                           id_illegal
);
    import axo_pkg::*;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic                  illegal;
    logic                  has_rd;
    logic                  flush;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_b;
    logic [xlen-1:0]       imm_j;
    logic [xlen-1:0]       rs1_fwd;
    logic [xlen-1:0]       rs2_fwd;
    logic [xlen-1:0]       lhs;
    logic [xlen-1:0]       rhs;
    logic                  alt_bit;

    assign opcode = opcode_e'(if_insn[6:0]);
    assign funct3 = if_insn[14:12];
    assign rs1    = if_insn[19:15];
    assign rs2    = if_insn[24:20];
    assign flush  = trap || branch_error;

    assign imm_i = {{20{if_insn[31]}}, if_insn[31:20]};
    assign imm_b = {{19{if_insn[31]}}, if_insn[31], if_insn[7], if_insn[30:25],
                    if_insn[11:8], 1'b0};
    assign imm_j = {{11{if_insn[31]}}, if_insn[31], if_insn[19:12], if_insn[20],
                    if_insn[30:21], 1'b0};

    // Forward the result being written back this cycle.
    assign rs1_fwd = (ex_valid && ex_rd != '0 && ex_rd == rs1) ? ex_result : rs1_val;
    assign rs2_fwd = (ex_valid && ex_rd != '0 && ex_rd == rs2) ? ex_result : rs2_val;

    // Legality and destination register.
    always_comb begin
        illegal = 1'b0;
        has_rd  = 1'b1;
        case (opcode)
            op_load, op_op, op_imm, op_lui, op_auipc, op_jal, op_jalr: ;
            op_store, op_branch: has_rd = 1'b0;
            // Only the CSR forms of SYSTEM exist here.
            op_system: illegal = (funct3[1:0] == 2'b00);
            default: illegal = 1'b1;
        endcase
    end

    // Operands.
    always_comb begin
        case (opcode)
            op_lui:                  lhs = '0;
            op_auipc, op_jal, op_jalr: lhs = if_pc;
            default:                 lhs = rs1_fwd;
        endcase
        case (opcode)
            // Link offset.
            op_jal, op_jalr:  rhs = 32'd4;
            op_lui, op_auipc: rhs = {if_insn[31:12], 12'b0};
            op_imm, op_load:  rhs = imm_i;
            default:          rhs = rs2_fwd;
        endcase
    end

    // Bit 30 selects sub and sra only.
    assign alt_bit = if_insn[30] && ((opcode == op_op && funct3 == 3'b000) ||
                                     funct3 == 3'b101);

    // Jump targets, and backward branches predicted taken.
    always_comb begin
        case (opcode)
            op_jal:  branch_target = if_pc + imm_j;
            op_jalr: branch_target = (rs1_fwd + imm_i) & ~32'd1;
            default: branch_target = if_pc + imm_b;
        endcase
    end

    assign predict_taken = if_valid && !flush &&
        (opcode == op_jal || opcode == op_jalr || (opcode == op_branch && if_insn[31]));

    // Decode/execute register.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= if_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        id_pc      <= if_pc;
        id_insn    <= if_insn;
        id_lhs     <= lhs;
        id_rhs     <= rhs;
        id_rd      <= (has_rd && !illegal) ? if_insn[11:7] : '0;
        id_predict <= predict_taken;
        id_illegal <= illegal;
        if (opcode == op_op || opcode == op_imm) begin
            id_alu_op <= alu_op_e'({alt_bit, funct3});
        end else begin
            id_alu_op <= alu_add;
        end
    end

endmodule

//--- axo_execute.sv
`timescale 1ns/1ps
/*
 * Execute stage: ALU, branch resolution, data memory access,
 * CSR operand forming, result selection and trap raising.
 */
module axo_execute (
    input  logic                           id_valid,
    input  logic [axo_pkg::xlen-1:0]       id_pc,
    input  logic [axo_pkg::xlen-1:0]       id_insn,
    input  logic [axo_pkg::xlen-1:0]       id_lhs,
    input  logic [axo_pkg::xlen-1:0]       id_rhs,
    input  logic [axo_pkg::reg_addr_w-1:0] id_rd,
    input  axo_pkg::alu_op_e               id_alu_op,
    input  logic                           id_predict,
    input  logic                           id_illegal,
    input  logic [axo_pkg::xlen-1:0]       mem_rdata,
    input  logic [axo_pkg::xlen-1:0]       csr_rdata,
    input  logic                           csr_invalid,
    output logic                           mem_we,
    output logic                           mem_re,
    output logic [axo_pkg::xlen-1:0]       mem_addr,
    output logic [axo_pkg::xlen-1:0]       mem_wdata,
    output logic                           ex_valid,
    output logic [axo_pkg::reg_addr_w-1:0] ex_rd,
    output logic [axo_pkg::xlen-1:0]       ex_result,
    output logic                           branch_error,
    output logic                           trap,
    output logic [11:0]                    csr_addr,
    output logic [axo_pkg::xlen-1:0]       csr_wdata,
    output logic                           csr_we,
    output logic [axo_pkg::xlen-1:0]       ex_pc
);
    import axo_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] csr_src;
    logic            is_csr;
    logic            taken;

    assign opcode = opcode_e'(id_insn[6:0]);
    assign funct3 = id_insn[14:12];
    assign imm_s  = {{20{id_insn[31]}}, id_insn[31:25], id_insn[11:7]};
    assign is_csr = (opcode == op_system);

    // ALU.
    always_comb begin
        case (id_alu_op)
            alu_add:  alu_res = id_lhs + id_rhs;
            alu_sub:  alu_res = id_lhs - id_rhs;
            alu_sll:  alu_res = id_lhs << id_rhs[4:0];
            alu_slt:  alu_res = {31'b0, $signed(id_lhs) < $signed(id_rhs)};
            alu_sltu: alu_res = {31'b0, id_lhs < id_rhs};
            alu_xor:  alu_res = id_lhs ^ id_rhs;
            alu_srl:  alu_res = id_lhs >> id_rhs[4:0];
            alu_sra:  alu_res = $unsigned($signed(id_lhs) >>> id_rhs[4:0]);
            alu_or:   alu_res = id_lhs | id_rhs;
            default:  alu_res = id_lhs & id_rhs;
        endcase
    end

    // Branch comparator.
    always_comb begin
        case (funct3)
            3'b000:  taken = (id_lhs == id_rhs);
            3'b001:  taken = (id_lhs != id_rhs);
            3'b100:  taken = ($signed(id_lhs) < $signed(id_rhs));
            3'b101:  taken = ($signed(id_lhs) >= $signed(id_rhs));
            3'b110:  taken = (id_lhs < id_rhs);
            default: taken = (id_lhs >= id_rhs);
        endcase
    end

    // Outcome differs from the decode-time guess.
    assign branch_error = id_valid && !id_illegal && opcode == op_branch && taken != id_predict;

    // CSR access. Immediate forms take the rs1 field as data.
    assign csr_addr = id_insn[31:20];
    assign csr_src  = funct3[2] ? {27'b0, id_insn[19:15]} : id_lhs;
    always_comb begin
        case (funct3[1:0])
            2'b01:   csr_wdata = csr_src;
            2'b10:   csr_wdata = csr_rdata | csr_src;
            default: csr_wdata = csr_rdata & ~csr_src;
        endcase
    end
    // Set and clear with x0 or zero only read.
    assign csr_we = id_valid && !id_illegal && is_csr &&
                    (funct3[1:0] == 2'b01 || id_insn[19:15] != 5'd0);

    // Trap kills this instruction's side effects.
    assign trap     = id_valid && (id_illegal || (is_csr && csr_invalid));
    assign ex_valid = id_valid && !trap;
    assign ex_rd    = id_rd;
    assign ex_pc    = id_pc;

    // Data memory, word accesses only.
    assign mem_we    = ex_valid && opcode == op_store;
    assign mem_re    = ex_valid && opcode == op_load;
    assign mem_addr  = (opcode == op_store) ? id_lhs + imm_s : alu_res;
    assign mem_wdata = id_rhs;

    // Writeback value.
    always_comb begin
        if (opcode == op_load) begin
            ex_result = mem_rdata;
        end else if (is_csr) begin
            ex_result = csr_rdata;
        end else begin
            ex_result = alu_res;
        end
    end

endmodule

//--- axo_csr_file.sv
`timescale 1ns/1ps
/*
 * Machine-mode CSR file with access checks and trap entry.
 */
module axo_csr_file (
    input  logic                     clk,
    input  logic                     rst_latch,
    input  logic [11:0]              csr_addr,
    input  logic [axo_pkg::xlen-1:0] csr_wdata,
    input  logic                     csr_we,
    input  logic                     trap,
    input  logic [axo_pkg::xlen-1:0] ex_pc,
    output logic [axo_pkg::xlen-1:0] csr_rdata,
    output logic                     csr_invalid,
    output logic [axo_pkg::xlen-1:0] trap_vec
);
    import axo_pkg::*;

    // mstatus interrupt enable bits.
    logic            mstatus_mie;
    logic            mstatus_mpie;
    logic [xlen-1:0] mie;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mepc;
    logic [4:0]      mcause;
    // Address decode flags.
    logic            exists;
    logic            writable;

    // Direct mode only.
    assign trap_vec = {mtvec[xlen-1:2], 2'b00};

    // Read and permission decode.
    always_comb begin
        exists    = 1'b1;
        writable  = 1'b1;
        csr_rdata = '0;
        case (csr_addr_e'(csr_addr))
            csr_mstatus:  csr_rdata = {24'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
            csr_mie:      csr_rdata = mie;
            csr_mtvec:    csr_rdata = mtvec;
            csr_mscratch: csr_rdata = mscratch;
            csr_mepc:     csr_rdata = mepc;
            csr_mcause:   csr_rdata = {27'b0, mcause};
            csr_mhartid: begin
                csr_rdata = mhartid_value;
                writable  = 1'b0;
            end
            default: begin
                exists   = 1'b0;
                writable = 1'b0;
            end
        endcase
    end

    assign csr_invalid = !exists || (!writable && csr_we);

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else if (trap) begin
            // Trap entry. Only illegal instructions trap here.
            mepc         <= ex_pc;
            mcause       <= cause_illegal;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (csr_we) begin
            case (csr_addr_e'(csr_addr))
                csr_mstatus: begin
                    mstatus_mie  <= csr_wdata[3];
                    mstatus_mpie <= csr_wdata[7];
                end
                csr_mie:      mie      <= csr_wdata;
                csr_mtvec:    mtvec    <= csr_wdata;
                csr_mscratch: mscratch <= csr_wdata;
                csr_mepc:     mepc     <= {csr_wdata[xlen-1:2], 2'b00};
                csr_mcause:   mcause   <= csr_wdata[4:0];
                default: ;
            endcase
        end
    end

endmodule

//--- axo_core.sv
`timescale 1ns/1ps
/*
 * Three-stage RV32I core with machine CSRs. Top level wiring only.
 */
module axo_core (
    input  logic                     clk,
    input  logic                     rst_latch,
    output logic [axo_pkg::xlen-1:0] prog_addr,
    input  logic [axo_pkg::xlen-1:0] prog_data,
    output logic                     mem_we,
    output logic                     mem_re,
    output logic [axo_pkg::xlen-1:0] mem_addr,
    output logic [axo_pkg::xlen-1:0] mem_wdata,
    input  logic [axo_pkg::xlen-1:0] mem_rdata
);
    import axo_pkg::*;

    // Redirects.
    logic                  trap;
    logic                  branch_error;
    logic                  predict_taken;
    logic [xlen-1:0]       branch_target;
    logic [xlen-1:0]       trap_vec;
    // Fetch/decode register.
    logic                  if_valid;
    logic [xlen-1:0]       if_pc;
    logic [xlen-1:0]       if_insn;
    // Register file ports.
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    // Decode/execute register.
    logic                  id_valid;
    logic [xlen-1:0]       id_pc;
    logic [xlen-1:0]       id_insn;
    logic [xlen-1:0]       id_lhs;
    logic [xlen-1:0]       id_rhs;
    logic [reg_addr_w-1:0] id_rd;
    alu_op_e               id_alu_op;
    logic                  id_predict;
    logic                  id_illegal;
    // Writeback and CSR traffic.
    logic                  ex_valid;
    logic [reg_addr_w-1:0] ex_rd;
    logic [xlen-1:0]       ex_result;
    logic [xlen-1:0]       ex_pc;
    logic [11:0]           csr_addr;
    logic [xlen-1:0]       csr_wdata;
    logic                  csr_we;
    logic [xlen-1:0]       csr_rdata;
    logic                  csr_invalid;

    axo_fetch fetch_inst (
        .clk, .rst_latch, .prog_data, .trap, .trap_vec, .branch_error,
        .predict_taken, .branch_target, .prog_addr, .if_valid, .if_pc, .if_insn
    );

    axo_regfile regfile_inst (
        .clk, .rs1, .rs2, .rd(ex_rd), .we(ex_valid), .wdata(ex_result),
        .rs1_val, .rs2_val
    );

    axo_decode decode_inst (
        .clk, .rst_latch, .if_valid, .if_pc, .if_insn, .rs1_val, .rs2_val,
        .ex_rd, .ex_result, .ex_valid, .trap, .branch_error, .rs1, .rs2,
        .predict_taken, .branch_target, .id_valid, .id_pc, .id_insn, .id_lhs,
        .id_rhs, .id_rd, .id_alu_op, .id_predict, .id_illegal
    );

    axo_execute execute_inst (
        .id_valid, .id_pc, .id_insn, .id_lhs, .id_rhs, .id_rd, .id_alu_op,
        .id_predict, .id_illegal, .mem_rdata, .csr_rdata, .csr_invalid,
        .mem_we, .mem_re, .mem_addr, .mem_wdata, .ex_valid, .ex_rd, .ex_result,
        .branch_error, .trap, .csr_addr, .csr_wdata, .csr_we, .ex_pc
    );

    axo_csr_file csr_file_inst (
        .clk, .rst_latch, .csr_addr, .csr_wdata, .csr_we, .trap, .ex_pc,
        .csr_rdata, .csr_invalid, .trap_vec
    );

endmodule

//--- axo_core_asserts.sv
`timescale 1ns/1ps
/*
 * Data port assertions for axo_core, attached by bind.
 */
module axo_core_asserts (
    input logic        clk,
    input logic        rst_latch,
    input logic        mem_we,
    input logic        mem_re,
    input logic [31:0] mem_addr
);

    // Reads and writes are exclusive.
    assert property (@(posedge clk) disable iff (rst_latch) !(mem_we && mem_re))
        else $error("mem_we and mem_re high together");

    // Pipeline starts empty.
    assert property (@(posedge clk) $fell(rst_latch) |-> (!mem_we && !mem_re))
        else $error("data access in the first cycle after reset");

    // Word accesses only.
    assert property (@(posedge clk) disable iff (rst_latch)
        (mem_we || mem_re) |-> (mem_addr[1:0] == 2'b00))
        else $error("data access to an unaligned address");

endmodule

bind axo_core axo_core_asserts asserts_inst (
    .clk, .rst_latch, .mem_we, .mem_re, .mem_addr
);

//--- tb_clock_gen.sv
`timescale 1ns/1ps
/*
 * Testbench clock at an 8 ns period, with a 5-cycle reset pulse.
 */
module tb_clock_gen (
    output logic clk,
    output logic rst_latch
);

    // Reset held from time zero until the first pulse ends.
    initial begin
        clk       = 1'b0;
        rst_latch = 1'b1;
    end

    always #4 clk = ~clk;

    // Reset high for 5 rising edges.
    task automatic reset_pulse();
        @(posedge clk);
        rst_latch <= 1'b1;
        repeat (5) @(posedge clk);
        rst_latch <= 1'b0;
    endtask

endmodule

//--- tb_axo_core.sv
`timescale 1ns/1ps
/*
 * Testbench for axo_core. Runs the programs of the golden file and
 * compares every data store with the expected address and data.
 */
module tb_axo_core;
    import axo_pkg::*;

    logic        clk;
    logic        rst_latch;
    logic [31:0] prog_addr;
    logic [31:0] prog_data;
    logic        mem_we;
    logic        mem_re;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    // Golden words, program memory and data memory.
    logic [31:0] golden [0:511];
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];

    int errors;
    int checks;
    int exp_base;
    int n_expected;
    int seen;
    int budget;
    bit running;
    bit budget_ready;

    tb_clock_gen clock_inst (.clk, .rst_latch);

    axo_core axo_core_inst (
        .clk, .rst_latch, .prog_addr, .prog_data, .mem_we, .mem_re,
        .mem_addr, .mem_wdata, .mem_rdata
    );

    // Zero-wait memories. Outside the program window reads give zero.
    assign prog_data = (prog_addr[31:8] == entrypoint[31:8]) ? imem[prog_addr[7:2]] : '0;
    // Data comes back only for a load.
    assign mem_rdata = mem_re ? dmem[mem_addr[7:2]] : '0;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Store monitor, also the data memory write port.
    always @(posedge clk) begin
        if (running && !rst_latch && mem_we) begin
            if (seen < n_expected) begin
                check_value("mem_addr", mem_addr, golden[exp_base + 2 * seen]);
                check_value("mem_wdata", mem_wdata, golden[exp_base + 2 * seen + 1]);
            end
            dmem[mem_addr[7:2]] <= mem_wdata;
            seen++;
        end
    end

    // One golden block: header, program, data, store pairs.
    task automatic run_test(input int num, inout int base);
        int n_prog;
        int n_data;
        int err_start;
        n_prog  = golden[base];
        n_data  = golden[base + 1];
        running = 1'b0;
        clock_inst.reset_pulse();
        // Memories load at the last reset edge.
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < n_prog) ? golden[base + 3 + i] : 32'h0;
            dmem[i] = (i < n_data) ? golden[base + 3 + n_prog + i] : $urandom;
        end
        exp_base   = base + 3 + n_prog + n_data;
        n_expected = golden[base + 2];
        seen       = 0;
        err_start  = errors;
        running = 1'b1;
        wait (seen == n_expected);
        running = 1'b0;
        $display("Test %0d: %0d stores seen, %0d errors", num, seen, errors - err_start);
        base = exp_base + 2 * n_expected;
    endtask

    initial begin
        int seed;
        int base;
        int num;
        int total_stores;
        errors       = 0;
        checks       = 0;
        running      = 1'b0;
        seen         = 0;
        n_expected   = 0;
        exp_base     = 0;
        budget_ready = 1'b0;
        seed = $urandom(32'h948b);
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        $readmemh("core_golden.txt", golden);
        // Size the watchdog from the expected stores.
        base         = 0;
        num          = 0;
        total_stores = 0;
        while (golden[base] != 0) begin
            total_stores += golden[base + 2];
            base += 3 + golden[base] + golden[base + 1] + 2 * golden[base + 2];
            num++;
        end
        budget       = 200 * total_stores + 20 * num;
        budget_ready = 1'b1;
        base = 0;
        num  = 0;
        while (golden[base] != 0) begin
            num++;
            run_test(num, base);
        end
        $display("Tests %0d, checks %0d, errors %0d", num, checks, errors);
        if (errors == 0 && num > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        wait (budget_ready);
        repeat (budget) @(posedge clk);
        $display("Run timed out before all expected stores were seen");
        $display("Checks failed");
        $finish;
    end

endmodule

//--- core_golden.txt
// Per test, all hex: program words, data words, store count; then program words,
// initial data words, and expected store pairs (address, data). 0 0 0 ends the file.
// ALU, LUI and AUIPC
11 0 7
00500093 FFD00113 002081B3 00302023 40208233 00402223 001122B3 00502423
40115313 00602623 123453B7 00702823 00001417 00802A23 0FF0C493 00902C23
0000006F
00000000 00000002  00000004 00000008  00000008 00000001  0000000C FFFFFFFE
00000010 12345000  00000014 40001030  00000018 000000FA
// Backward loop and a mispredicted forward branch
C 0 2
00300093 00000113 00110133 FFF08093 FE009CE3 00202023 00000663 06300113
00202223 00110193 00302423 0000006F
00000000 00000006  00000008 00000007
// Forwarding and loads
A 2 3
00100093 00208093 00108133 00202823 00002183 00518213 00402A23 00402283
00502C23 0000006F
00000064 DEADBEEF
00000010 00000006  00000014 00000069  00000018 DEADBEEF
// JAL and JALR
8 0 2
00C000EF 04D00293 00502023 00102023 01408167 00502223 00202223 0000006F
00000000 40000004  00000004 40000014
// CSR access and the illegal opcode trap
15 0 5
400000B7 04008093 30509073 05A00113 34011073 3402E073 340571F3 00302023
34002273 00402223 08800293 30429373 304023F3 00702423 00000000 00000000
34102473 00802623 342024F3 00902823 0000006F
00000000 0000005F  00000004 00000055  00000008 00000088  0000000C 40000038
00000010 00000002
// Write to mhartid traps
F 0 3
400000B7 02008093 30509073 F140D073 00100113 00202023 00000000 00000000
341021F3 00302023 34202273 00402223 F14022F3 00502423 0000006F
00000000 4000000C  00000004 00000002  00000008 00000000
0 0 0

//--- verilog.f
axo_pkg.sv
axo_fetch.sv
axo_regfile.sv
axo_decode.sv
axo_execute.sv
axo_csr_file.sv
axo_core.sv
axo_core_asserts.sv
tb_clock_gen.sv
tb_axo_core.sv

//--- Bender.yml
package:
  name: axo_core

sources:
  - axo_pkg.sv
  - axo_fetch.sv
  - axo_regfile.sv
  - axo_decode.sv
  - axo_execute.sv
  - axo_csr_file.sv
  - axo_core.sv
  - target: test
    files:
      - axo_core_asserts.sv
      - tb_clock_gen.sv
      - tb_axo_core.sv
